// File: bench/time_core_tests.txt
# name op arg_a arg_b (hex). write: addr data. read: addr expected.
# readm: addr, model value. wait: cycles. event: expected time.
reset_count wait 14 0
reset_count readm 0 0
reset_count readm 1 0
load_now wrand 0 0
load_now wrand 1 0
load_now write 2 1
load_now wait 5 0
load_now readm 0 0
load_now readm 1 0
pps_load write 0 00000002
pps_load write 1 fffffff0
pps_load write 2 2
pps_load wait a 0
pps_load pps 0 0
pps_load wait 6 0
pps_load readm 2 0
pps_load readm 3 0
pps_load readm 0 0
pps_load readm 1 0
pps_only wait 8 0
pps_only pps 0 0
pps_only wait 6 0
pps_only readm 2 0
pps_only readm 3 0
pps_only wait 1e 0
pps_only pps 0 0
pps_only wait 6 0
pps_only readm 2 0
pps_only readm 3 0
evt_future write 0 00000001
evt_future write 1 00000000
evt_future write 2 1
evt_future wait 4 0
evt_future write 3 00000001
evt_future write 4 00000040
evt_future write 5 0
evt_future event 0 100000040
evt_future read 4 0
evt_late write 4 00000010
evt_late write 5 0
evt_late late 0 0
evt_late read 4 2
snapshot readm 0 0
snapshot wait 19 0
snapshot readm 1 0
snapshot readm 2 0
snapshot wait 9 0
snapshot readm 3 0
unmapped read 9 0

// File: compile.f
logic/time_pkg.sv
logic/setting_reg.sv
logic/timekeeper.sv
logic/event_scheduler.sv
logic/readback_mux.sv
logic/time_core.sv
bench/tb_clock.sv
bench/time_core_tb.sv

// File: Makefile
# Verilator build and run for the time core testbench.

VERILATOR ?= verilator
TOP       ?= time_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES   := $(shell grep -v '^+' compile.f)
TESTS     := bench/time_core_tests.txt
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) compile.f
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN) $(TESTS)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/time_core_tb.sv
//************************************************************
// Time core testbench. Runs the operations from the test
// file against a cycle model of the time rules.
//************************************************************
module time_core_tb;

   logic                clk;
   logic                reset;
   logic                pps;
   logic                set_stb;
   time_pkg::set_addr_t set_addr;
   time_pkg::set_data_t set_data;
   logic                rb_stb;
   time_pkg::set_addr_t rb_addr;
   time_pkg::set_data_t rb_data;
   logic                rb_valid;
   time_pkg::time_t     vita_time;
   logic                evt_stb;
   logic                late_stb;

   tb_clock tb_clock_inst (.clk(clk), .reset(reset));

   time_core time_core_inst (
      .clk(clk), .reset(reset), .pps(pps),
      .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
      .rb_stb(rb_stb), .rb_addr(rb_addr), .rb_data(rb_data), .rb_valid(rb_valid),
      .vita_time(vita_time), .evt_stb(evt_stb), .late_stb(late_stb)
   );

   //*********************************************************
   // Test table and model state
   //*********************************************************
   string               name_q[$];                    // Test name per line.
   string               op_q[$];                      // Operation per line.
   logic [63:0]         arg_a_q[$];
   logic [63:0]         arg_b_q[$];
   string               cur_name = "reset";
   int                  cycle_count = 0;
   int                  cycle_limit = 0;              // Zero until file is read.
   int                  error_count = 0;
   logic [31:0]         lfsr_state = 32'h7034fc07;
   time_pkg::time_t     model_time;                   // Expected vita_time.
   time_pkg::time_t     model_lastpps;
   time_pkg::set_data_t model_new_hi;
   time_pkg::set_data_t model_new_lo;
   logic [1:0]          model_mode;                   // Load now, load at PPS.
   logic                model_armed;                  // Load pending.
   logic                arm_pending;                  // Armed at next edge.
   logic                pps_prev;                     // PPS level at last edge.
   int                  pps_count;                    // Edges to PPS event.
   time_pkg::set_data_t time_lo_snap;
   time_pkg::set_data_t pps_lo_snap;
   logic                want_evt = 1'b0;
   logic                want_late = 1'b0;

   //*********************************************************
   // Failure and compare tasks
   //*********************************************************
   task automatic stop_run(input string why);
      error_count++;
      $display("%s", why);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_time(input string name, input time_pkg::time_t exp,
                             input time_pkg::time_t act);
      if (act !== exp) begin
         stop_run($sformatf("[ERROR] %s expected %016h actual %016h", name, exp, act));
      end
   endtask

   task automatic check_word(input string name, input time_pkg::set_data_t exp,
                             input time_pkg::set_data_t act);
      if (act !== exp) begin
         stop_run($sformatf("[ERROR] %s expected %08h actual %08h", name, exp, act));
      end
   endtask

   // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) begin
         s = s ^ 32'h80200003;
      end
      return s;
   endfunction

   task automatic random_word(output time_pkg::set_data_t w);
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);          // One step per bit.
         w[i]       = lfsr_state[0];
      end
   endtask

   //*********************************************************
   // One clock cycle of the model
   //*********************************************************
   task automatic clock_cycle();
      logic            pps_event;
      logic            load;
      time_pkg::time_t loaded;
      @(posedge clk);
      pps_event = (pps_count == 1);                   // Two edges after the rise.
      load      = model_armed && (model_mode[0] || (model_mode[1] && pps_event));
      loaded    = {model_new_hi, model_new_lo};
      if (pps_event) begin
         model_lastpps = model_time;                  // Time before the load.
      end
      if (pps_count > 0) begin
         pps_count--;
      end
      if (pps && !pps_prev) begin
         pps_count = 2;
      end
      pps_prev = pps;
      if (arm_pending) begin
         model_armed = 1'b1;
      end else if (load) begin
         model_armed = 1'b0;
      end
      arm_pending = 1'b0;
      if (set_stb) begin                              // Settings sampled here.
         if (set_addr == time_pkg::SR_TIME_HI) model_new_hi = set_data;
         if (set_addr == time_pkg::SR_TIME_LO) model_new_lo = set_data;
         if (set_addr == time_pkg::SR_TIME_CTRL) begin
            model_mode  = set_data[1:0];
            arm_pending = 1'b1;
         end
      end
      model_time = load ? loaded : model_time + 64'd1;
      @(negedge clk);
      check_time(cur_name, model_time, vita_time);    // Every cycle.
      if ((evt_stb && !want_evt) || (late_stb && !want_late)) begin
         stop_run($sformatf("%s: event strobe raised when none was due", cur_name));
      end
   endtask

   //*********************************************************
   // Operations
   //*********************************************************
   task automatic bus_write(input time_pkg::set_addr_t a, input time_pkg::set_data_t d);
      set_stb  = 1'b1;
      set_addr = a;
      set_data = d;
      clock_cycle();
      set_stb  = 1'b0;
   endtask

   task automatic bus_read(input time_pkg::set_addr_t a, input time_pkg::set_data_t exp);
      rb_stb  = 1'b1;
      rb_addr = a;
      clock_cycle();
      rb_stb  = 1'b0;
      if (rb_valid !== 1'b1) begin
         stop_run($sformatf("%s: readback valid missing one cycle after the request",
                            cur_name));
      end
      check_word(cur_name, exp, rb_data);
   endtask

   // Expected word for a time read, with the LO half held at the HI read.
   task automatic model_read(input time_pkg::set_addr_t a);
      time_pkg::set_data_t exp;
      case (a)
         time_pkg::RB_TIME_HI: begin
            exp          = model_time[63:32];
            time_lo_snap = model_time[31:0];
         end
         time_pkg::RB_TIME_LO: exp = time_lo_snap;
         time_pkg::RB_PPS_HI: begin
            exp         = model_lastpps[63:32];
            pps_lo_snap = model_lastpps[31:0];
         end
         time_pkg::RB_PPS_LO: exp = pps_lo_snap;
         default: exp = '0;
      endcase
      bus_read(a, exp);
   endtask

   task automatic run_op(input string op, input logic [63:0] a, input logic [63:0] b);
      time_pkg::set_data_t w;
      case (op)
         "write": bus_write(a[7:0], b[31:0]);
         "wrand": begin
            random_word(w);
            bus_write(a[7:0], w);
         end
         "pps": begin
            pps = 1'b1;
            repeat (3) clock_cycle();
            pps = 1'b0;
            clock_cycle();
         end
         "wait": repeat (a) clock_cycle();
         "read": bus_read(a[7:0], b[31:0]);
         "readm": model_read(a[7:0]);
         "event": begin
            want_evt = 1'b1;
            do clock_cycle(); while (!evt_stb);
            check_time(cur_name, b, vita_time);      // Strobe at target time.
            want_evt = 1'b0;
            clock_cycle();                           // Strobe lasts one cycle.
         end
         "late": begin
            want_late = 1'b1;
            do clock_cycle(); while (!late_stb);
            want_late = 1'b0;
            clock_cycle();                           // Disarmed after the pulse.
         end
         default: stop_run($sformatf("%s: unknown operation %s", cur_name, op));
      endcase
   endtask

   //*********************************************************
   // Timeout
   //*********************************************************
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
         stop_run("run did not finish before the cycle limit");
      end
   end

   //*********************************************************
   // Main sequence
   //*********************************************************
   initial begin
      int          fd;
      int          waits;
      string       line;
      string       name;
      string       op;
      logic [63:0] a;
      logic [63:0] b;
      pps      = 1'b0;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      rb_stb   = 1'b0;
      rb_addr  = '0;
      waits    = 0;
      fd = $fopen("bench/time_core_tests.txt", "r");
      if (fd == 0) begin
         stop_run("could not open the test file");
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            if ($sscanf(line, "%s %s %h %h", name, op, a, b) == 4) begin
               name_q.push_back(name);
               op_q.push_back(op);
               arg_a_q.push_back(a);
               arg_b_q.push_back(b);
               if (op == "wait") waits += int'(a);
            end
         end
      end
      $fclose(fd);
      cycle_limit = waits + 8 * name_q.size() + 100;  // Scaled to the file.

      @(negedge reset);                               // Released on a falling edge.
      model_time    = '0;
      model_lastpps = '0;
      model_new_hi  = '0;
      model_new_lo  = '0;
      model_mode    = '0;
      model_armed   = 1'b0;
      arm_pending   = 1'b0;
      pps_prev      = 1'b0;
      pps_count     = 0;
      time_lo_snap  = '0;
      pps_lo_snap   = '0;
      check_time(cur_name, model_time, vita_time);    // Zero out of reset.

      foreach (op_q[i]) begin
         cur_name = name_q[i];
         run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
      end

      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: bench/tb_clock.sv
//************************************************************
// Testbench clock and reset. Period 10, reset for 16 cycles.
//************************************************************
module tb_clock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                          // Period of 10.
   end

   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);                     // Hold for 16 cycles.
      @(negedge clk);
      reset = 1'b0;                                   // Release on falling edge.
   end

endmodule

// File: logic/time_core.sv
//************************************************************
// Time core top. Timekeeper, event scheduler and readback
// on one settings bus.
//************************************************************
module time_core (
   input  logic                clk,
   input  logic                reset,
   input  logic                pps,                   // Raw PPS input.

   // Settings bus.
   input  logic                set_stb,
   input  time_pkg::set_addr_t set_addr,
   input  time_pkg::set_data_t set_data,

   // Readback.
   input  logic                rb_stb,
   input  time_pkg::set_addr_t rb_addr,
   output time_pkg::set_data_t rb_data,
   output logic                rb_valid,

   // Time and events.
   output time_pkg::time_t     vita_time,
   output logic                evt_stb,
   output logic                late_stb
);

   //*********************************************************
   // Internal nets
   //*********************************************************
   time_pkg::time_t vita_time_lastpps;                // Time at last PPS.
   logic            evt_armed;                        // Scheduler waiting.
   logic            late_seen;                        // Last arm was late.

   timekeeper timekeeper_inst (
      .clk               (clk),
      .reset             (reset),
      .pps               (pps),
      .set_stb           (set_stb),
      .set_addr          (set_addr),
      .set_data          (set_data),
      .vita_time         (vita_time),
      .vita_time_lastpps (vita_time_lastpps)
   );

   event_scheduler event_scheduler_inst (
      .clk       (clk),
      .reset     (reset),
      .set_stb   (set_stb),
      .set_addr  (set_addr),
      .set_data  (set_data),
      .vita_time (vita_time),
      .evt_stb   (evt_stb),
      .late_stb  (late_stb),
      .evt_armed (evt_armed),
      .late_seen (late_seen)
   );

   readback_mux readback_mux_inst (
      .clk               (clk),
      .reset             (reset),
      .rb_stb            (rb_stb),
      .rb_addr           (rb_addr),
      .vita_time         (vita_time),
      .vita_time_lastpps (vita_time_lastpps),
      .evt_armed         (evt_armed),
      .late_seen         (late_seen),
      .rb_data           (rb_data),
      .rb_valid          (rb_valid)
   );

endmodule

// File: logic/readback_mux.sv
//************************************************************
// Readback mux. Registered word select with a LO-half
// snapshot taken at each HI read of a 64-bit value.
//************************************************************
module readback_mux (
   input  logic                clk,
   input  logic                reset,
   input  logic                rb_stb,                // Read request.
   input  time_pkg::set_addr_t rb_addr,               // Read address.
   input  time_pkg::time_t     vita_time,
   input  time_pkg::time_t     vita_time_lastpps,
   input  logic                evt_armed,
   input  logic                late_seen,
   output time_pkg::set_data_t rb_data,               // Word, one cycle later.
   output logic                rb_valid               // Marks rb_data.
);

   time_pkg::set_data_t time_lo_snap;                 // Held at RB_TIME_HI.
   time_pkg::set_data_t pps_lo_snap;                  // Held at RB_PPS_HI.
   time_pkg::set_data_t status_word;

   assign status_word = time_pkg::set_data_t'({late_seen, evt_armed});

   //*********************************************************
   // Word select and snapshots
   //*********************************************************
   always_ff @(posedge clk) begin
      if (rb_stb) begin
         case (rb_addr)
            time_pkg::RB_TIME_HI: begin
               rb_data      <= vita_time[63:32];
               time_lo_snap <= vita_time[31:0];      // Same cycle as HI.
            end
            time_pkg::RB_TIME_LO: begin
               rb_data <= time_lo_snap;
            end
            time_pkg::RB_PPS_HI: begin
               rb_data     <= vita_time_lastpps[63:32];
               pps_lo_snap <= vita_time_lastpps[31:0];
            end
            time_pkg::RB_PPS_LO: begin
               rb_data <= pps_lo_snap;
            end
            time_pkg::RB_STATUS: begin
               rb_data <= status_word;
            end
            default: begin
               rb_data <= '0;                         // Unmapped reads zero.
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rb_valid <= 1'b0;
      end else begin
         rb_valid <= rb_stb;                          // Fixed 1-cycle latency.
      end
   end

   // Host relies on a fixed latency with no spurious valid.
   valid_follows_stb : assert property (
      @(posedge clk) disable iff (reset) rb_valid |-> $past(rb_stb)
   );

endmodule

// File: logic/event_scheduler.sv
//************************************************************
// Event scheduler. Fires an on-time strobe when the time
// hits the target, or a late strobe if it is already past.
//************************************************************
module event_scheduler (
   input  logic                clk,
   input  logic                reset,
   input  logic                set_stb,
   input  time_pkg::set_addr_t set_addr,
   input  time_pkg::set_data_t set_data,
   input  time_pkg::time_t     vita_time,             // Current time.
   output logic                evt_stb,               // On-time pulse.
   output logic                late_stb,              // Missed target pulse.
   output logic                evt_armed,             // Waiting for target.
   output logic                late_seen              // Sticky until next arm.
);

   //*********************************************************
   // Target and arm registers
   //*********************************************************
   time_pkg::set_data_t target_hi;                    // Target, upper half.
   time_pkg::set_data_t target_lo;                    // Target, lower half.
   time_pkg::time_t     target;
   logic                arm_written;                  // Arm write pulse.

   setting_reg #(.ADDR(time_pkg::SR_EVT_HI), .payload_t(time_pkg::set_data_t)) sr_evt_hi (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(target_hi), .changed()
   );

   setting_reg #(.ADDR(time_pkg::SR_EVT_LO), .payload_t(time_pkg::set_data_t)) sr_evt_lo (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(target_lo), .changed()
   );

   // Only the write pulse matters here, so the stored bit goes nowhere.
   setting_reg #(.ADDR(time_pkg::SR_EVT_ARM), .payload_t(logic)) sr_evt_arm (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(), .changed(arm_written)
   );

   assign target = {target_hi, target_lo};

   //*********************************************************
   // Compare
   //*********************************************************
   logic armed;
   logic at_target;                                   // Time equals target.
   logic past_target;                                 // Time beyond target.

   assign at_target   = (vita_time == target);
   assign past_target = (vita_time > target);

   // Time steps by one, so past only shows in the first armed cycle
   // unless a load jumps the counter over the target.
   assign evt_stb   = armed && at_target;
   assign late_stb  = armed && past_target;
   assign evt_armed = armed;

   always_ff @(posedge clk) begin
      if (reset) begin
         armed <= 1'b0;
      end else if (arm_written) begin
         armed <= 1'b1;                               // Armed after E1.
      end else if (evt_stb || late_stb) begin
         armed <= 1'b0;                               // One pulse per arm.
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         late_seen <= 1'b0;
      end else if (arm_written) begin
         late_seen <= 1'b0;
      end else if (late_stb) begin
         late_seen <= 1'b1;
      end
   end

   // A disarm must follow every pulse, so none repeats without a new arm.
   pulse_once_per_arm : assert property (
      @(posedge clk) disable iff (reset)
      (evt_stb || late_stb) && !arm_written |=> !evt_stb && !late_stb
   );

endmodule

// File: logic/timekeeper.sv
//************************************************************
// Timekeeper. Free-running 64-bit sample time with PPS
// capture and a host load, either at once or at next PPS.
//************************************************************
module timekeeper (
   input  logic                clk,
   input  logic                reset,
   input  logic                pps,                   // Asynchronous PPS in.
   input  logic                set_stb,
   input  time_pkg::set_addr_t set_addr,
   input  time_pkg::set_data_t set_data,
   output time_pkg::time_t     vita_time,             // Current time.
   output time_pkg::time_t     vita_time_lastpps      // Time at last PPS edge.
);

   //*********************************************************
   // Settings
   //*********************************************************
   time_pkg::set_data_t new_time_hi;                  // Loaded time, upper.
   time_pkg::set_data_t new_time_lo;                  // Loaded time, lower.
   logic [1:0]          time_ctrl;                    // Load mode bits.
   logic                ctrl_written;                 // Control write pulse.
   logic                load_now;
   logic                load_pps;

   setting_reg #(.ADDR(time_pkg::SR_TIME_HI), .payload_t(time_pkg::set_data_t)) sr_time_hi (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(new_time_hi), .changed()
   );

   setting_reg #(.ADDR(time_pkg::SR_TIME_LO), .payload_t(time_pkg::set_data_t)) sr_time_lo (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(new_time_lo), .changed()
   );

   setting_reg #(.ADDR(time_pkg::SR_TIME_CTRL), .payload_t(logic [1:0])) sr_time_ctrl (
      .clk(clk), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
      .set_data(set_data), .value(time_ctrl), .changed(ctrl_written)
   );

   assign load_now = time_ctrl[0];                    // Bit 0 loads at once.
   assign load_pps = time_ctrl[1];                    // Bit 1 waits for PPS.

   //*********************************************************
   // PPS synchronizer and rising edge
   //*********************************************************
   logic pps_meta;                                    // First sync stage.
   logic pps_sync;                                    // Second sync stage.
   logic pps_last;                                    // Previous synced level.
   logic pps_edge;

   always_ff @(posedge clk) begin
      if (reset) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_last <= 1'b0;
      end else begin
         pps_meta <= pps;
         pps_sync <= pps_meta;
         pps_last <= pps_sync;
      end
   end

   assign pps_edge = pps_sync && !pps_last;           // One cycle per rise.

   // Host polls this to find the PPS.
   always_ff @(posedge clk) begin
      if (pps_edge) begin
         vita_time_lastpps <= vita_time;              // Time before any load.
      end
   end

   //*********************************************************
   // Armed load and time counter
   //*********************************************************
   logic armed;                                       // Load pending.
   logic time_event;                                  // Load this cycle.

   assign time_event = armed && (load_now || (load_pps && pps_edge));

   always_ff @(posedge clk) begin
      if (reset) begin
         armed <= 1'b0;
      end else if (ctrl_written) begin
         armed <= 1'b1;                               // One cycle after write.
      end else if (time_event) begin
         armed <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time <= '0;
      end else if (time_event) begin
         vita_time <= {new_time_hi, new_time_lo};
      end else begin
         vita_time <= vita_time + time_pkg::time_t'(1);
      end
   end

   // Armed only rises after a control write taken outside reset.
   armed_set_by_ctrl : assert property (
      @(posedge clk) $rose(armed) |-> $past(ctrl_written) && !$past(reset)
   );

endmodule

// File: logic/setting_reg.sv
//************************************************************
// Settings bus register. Matches one address, holds a
// typed value and pulses changed on each write.
//************************************************************
module setting_reg #(
   parameter time_pkg::set_addr_t ADDR = '0,          // Register address.
   parameter type payload_t = time_pkg::set_data_t    // Held value type.
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                set_stb,               // Write strobe.
   input  time_pkg::set_addr_t set_addr,              // Write address.
   input  time_pkg::set_data_t set_data,              // Write data.
   output payload_t            value,                 // Current setting.
   output logic                changed                // One-cycle write pulse.
);

   localparam int PAYLOAD_W = $bits(payload_t);      // Bits taken from data.

   logic hit;                                         // Address match this cycle.

   assign hit = set_stb && (set_addr == ADDR);

   // Value register. Low bits of the bus word only.
   always_ff @(posedge clk) begin
      if (reset) begin
         value <= '0;
      end else if (hit) begin
         value <= payload_t'(set_data[PAYLOAD_W-1:0]);
      end
   end

   // Changed follows every matching write, even with the same data.
   always_ff @(posedge clk) begin
      if (reset) begin
         changed <= 1'b0;
      end else begin
         changed <= hit;                              // High for one cycle.
      end
   end

endmodule

// File: logic/time_pkg.sv
//************************************************************
// Time subsystem package. Bus widths, register map,
// readback map and the shared time types.
//************************************************************
package time_pkg;

   //*********************************************************
   // Widths
   //*********************************************************
   localparam int TIME_W     = 64;                 // Sample-clock time.
   localparam int SET_ADDR_W = 8;                  // Settings bus address.
   localparam int SET_DATA_W = 32;                 // Settings bus data.

   typedef logic [TIME_W-1:0]     time_t;          // Full 64-bit time.
   typedef logic [SET_ADDR_W-1:0] set_addr_t;      // Bus address word.
   typedef logic [SET_DATA_W-1:0] set_data_t;      // Bus data word.

   //*********************************************************
   // Settings register map
   //*********************************************************
   // Timekeeper.
   localparam set_addr_t SR_TIME_HI   = 8'd0;      // New time, upper half.
   localparam set_addr_t SR_TIME_LO   = 8'd1;      // New time, lower half.
   localparam set_addr_t SR_TIME_CTRL = 8'd2;      // Bit 0 now, bit 1 at PPS.

   // Event scheduler.
   localparam set_addr_t SR_EVT_HI    = 8'd3;      // Target, upper half.
   localparam set_addr_t SR_EVT_LO    = 8'd4;      // Target, lower half.
   localparam set_addr_t SR_EVT_ARM   = 8'd5;      // Any write arms.

   //*********************************************************
   // Readback map
   //*********************************************************
   localparam set_addr_t RB_TIME_HI   = 8'd0;      // Current time, upper.
   localparam set_addr_t RB_TIME_LO   = 8'd1;      // Current time, lower.
   localparam set_addr_t RB_PPS_HI    = 8'd2;      // Last PPS time, upper.
   localparam set_addr_t RB_PPS_LO    = 8'd3;      // Last PPS time, lower.
   localparam set_addr_t RB_STATUS    = 8'd4;      // Bit 0 armed, bit 1 late.

endpackage
